/* hw/uopPkg.sv */
// Assumes ARM A32 encodings with NZCV flags and a scratch register Rz reached through the high register-file bit
package uopPkg;

	localparam int instrWidth = 32;                     // Instruction word
	localparam int regIdxWidth = 4;                     // Register number
	localparam int offsetWidth = 12;                    // Load immediate
	localparam int regListWidth = 16;                   // LDM register list
	localparam int listCountWidth = $clog2(regListWidth) + 1; // Holds 0 to 16
	localparam int ldmOffsetWidth = offsetWidth + 1;    // Signed running offset

	localparam logic [regIdxWidth-1:0] rzReg = 4'b1111; // Rz when paired with high regfile bit
	localparam logic [regIdxWidth-1:0] lrReg = 4'd14;   // Link register
	localparam logic [regIdxWidth-1:0] pcReg = 4'd15;   // Program counter

	localparam logic [3:0] opMov = 4'b1101;
	localparam logic [3:0] opAdd = 4'b0100;
	localparam logic [3:0] opTeq = 4'b1001;             // BX lives in TEQ space with S clear
	localparam logic [3:0] opNeverCond = 4'b1111;       // NV condition code

	localparam logic [1:0] kindDataProc = 2'b00;        // Bits 27:26 of data processing
	localparam logic [1:0] kindBranch = 2'b10;          // Bits 27:26 of B and BL
	localparam logic [2:0] kindSingle = 3'b010;         // Single load/store with immediate
	localparam logic [2:0] kindBlock = 3'b100;          // Block transfer
	localparam logic [3:0] mulSignature = 4'b1001;      // Bits 7:4 of every multiply
	localparam logic [7:0] bxOp2High = 8'hF1;           // SBO nibble plus BX tag

	localparam logic signed [ldmOffsetWidth-1:0] wordStep = 4; // One word per LDM load

	// Sequencer states
	typedef enum logic [2:0] {
		seqReady,    // Pass through or first micro-op
		seqRsr,      // Second half of register-shifted op
		seqMultiply, // Accumulate step
		seqBl,       // Plain branch after link move
		seqLdm       // Walking the register list
	} seqState;

	// Data processing view, also used for multiply and branch words
	typedef struct packed {
		logic [3:0] cond;
		logic [1:0] kind;                   // 27:26
		logic immFlag;                      // I bit
		logic [3:0] opcode;                 // 24:21
		logic setFlags;                     // S bit
		logic [regIdxWidth-1:0] rn;
		logic [regIdxWidth-1:0] rd;
		logic [offsetWidth-1:0] operand2;
	} dpFields;

	// Load/store view, block transfers keep their list in rd and offset
	typedef struct packed {
		logic [3:0] cond;
		logic [2:0] kind;                   // 27:25
		logic preIndex;                     // P bit
		logic up;                           // U bit
		logic byteMode;                     // B bit
		logic writeBack;                    // W bit
		logic load;                         // L bit
		logic [regIdxWidth-1:0] rn;
		logic [regIdxWidth-1:0] rd;
		logic [offsetWidth-1:0] offset;
	} lsFields;

	// One word, two decodings
	typedef union packed {
		dpFields dp;
		lsFields ls;
	} armInstr;

endpackage

/* hw/ldmWalkIf.sv */
// No handshake, the walker trusts ldmStart and advance to arrive only for issuing LDM micro-ops
interface ldmWalkIf;

	logic ldmStart;                          // First LDM micro-op
	logic advance;                           // Later LDM micro-op, unstalled
	logic [uopPkg::regIdxWidth-1:0] regNum;  // Destination of current load
	logic [uopPkg::offsetWidth-1:0] offset;  // Offset magnitude
	logic addUp;                             // U bit of current load
	logic lastReg;                           // Final load of the list

	modport expander (
		output ldmStart,
		output advance,
		input regNum,
		input offset,
		input addUp,
		input lastReg
	);

	modport walker (
		input ldmStart,
		input advance,
		output regNum,
		output offset,
		output addUp,
		output lastReg
	);

endinterface

/* hw/condCheck.sv */
// Flags arrive as N Z C V from bit 3 down and code 1111 is treated as never rather than unconditional
module condCheck (
	input logic [3:0] cond,
	input logic [3:0] flags,
	output logic condPass
);

	logic n, z, c, v;

	always_comb begin
		n = flags[3];
		z = flags[2];
		c = flags[1];
		v = flags[0];
		case (cond)
			4'b0000: condPass = z;                // EQ
			4'b0001: condPass = !z;               // NE
			4'b0010: condPass = c;                // CS
			4'b0011: condPass = !c;               // CC
			4'b0100: condPass = n;                // MI
			4'b0101: condPass = !n;               // PL
			4'b0110: condPass = v;                // VS
			4'b0111: condPass = !v;               // VC
			4'b1000: condPass = c && !z;          // HI
			4'b1001: condPass = !c || z;          // LS
			4'b1010: condPass = (n == v);         // GE
			4'b1011: condPass = (n != v);         // LT
			4'b1100: condPass = !z && (n == v);   // GT
			4'b1101: condPass = z || (n != v);    // LE
			4'b1110: condPass = 1'b1;             // AL
			uopPkg::opNeverCond: begin
				condPass = 1'b0;                  // NV
			end
		endcase
	end

endmodule

/* hw/regListWalker.sv */
// Only LDM walks are tracked and base writeback is ignored, an empty register list is not supported
module regListWalker (
	input logic clk,
	input logic reset,
	input uopPkg::armInstr instr,
	ldmWalkIf.walker walk
);

	logic [uopPkg::regListWidth-1:0] instrList;   // List as encoded
	logic [uopPkg::regListWidth-1:0] heldList;    // Registers still to load
	logic [uopPkg::regListWidth-1:0] curList;
	logic [uopPkg::regListWidth-1:0] nextList;
	logic [uopPkg::listCountWidth-1:0] listCount;
	logic signed [uopPkg::ldmOffsetWidth-1:0] listBytes;
	logic signed [uopPkg::ldmOffsetWidth-1:0] baseOffset;
	logic signed [uopPkg::ldmOffsetWidth-1:0] heldOffset;
	logic signed [uopPkg::ldmOffsetWidth-1:0] curOffset;

	// Base offset from addressing mode
	always_comb begin
		instrList = {instr.ls.rd, instr.ls.offset};  // Bits 15:0
		listCount = uopPkg::listCountWidth'($countones(instrList));
		listBytes = uopPkg::ldmOffsetWidth'({listCount, 2'b00}); // 4n
		case ({instr.ls.preIndex, instr.ls.up})
			2'b01: baseOffset = '0;                          // IA
			2'b11: baseOffset = uopPkg::wordStep;            // IB
			2'b00: baseOffset = uopPkg::wordStep - listBytes; // DA
			default: baseOffset = -listBytes;               // DB
		endcase
	end

	// Current load, first cycle reads straight from the instruction
	always_comb begin
		curList = walk.ldmStart ? instrList : heldList;
		curOffset = walk.ldmStart ? baseOffset : heldOffset;
		nextList = curList & (curList - 1'b1);       // Clear lowest set bit
		walk.regNum = '0;
		for (int i = uopPkg::regListWidth - 1; i >= 0; i--) begin
			if (curList[i])
				walk.regNum = uopPkg::regIdxWidth'(i); // Lowest wins
		end
		walk.lastReg = ($countones(curList) == 1);
		walk.addUp = (curOffset >= 0);               // Zero counts as up
		walk.offset = uopPkg::offsetWidth'((curOffset < 0) ? -curOffset : curOffset);
	end

	// ldmStart repeats under stall but reloads the same values
	always_ff @(posedge clk) begin
		if (reset) begin
			heldList <= '0;
		end else if (walk.ldmStart || walk.advance) begin
			heldList <= nextList;
		end
	end

	always_ff @(posedge clk) begin
		if (walk.ldmStart || walk.advance)
			heldOffset <= curOffset + uopPkg::wordStep; // Next word
	end

	// Expander must stop once lastReg has issued
	assert property (@(posedge clk) disable iff (reset)
		walk.advance |-> (heldList != '0))
		else $error("LDM advance with an empty remaining list");

endmodule

/* hw/uopExpander.sv */
// Mealy outputs follow instr every cycle, so fetch must hold the expanded instruction while uopStall is high
module uopExpander (
	input logic clk,
	input logic reset,
	input logic stall,
	input uopPkg::armInstr instr,
	input logic condPass,
	ldmWalkIf.expander walk,
	output logic instrMux,
	output logic noFlagUpdate,
	output logic uopStall,
	output logic keepV,
	output logic prevRsr,
	output logic ldmForward,
	output logic [3:0] regFileRz,
	output uopPkg::armInstr uopInstr
);

	uopPkg::seqState state, nextState;
	logic isBx, isRsr, isMulAcc, isBl, isLdm;
	uopPkg::armInstr rsrFirst, rsrSecond;
	uopPkg::armInstr mulFirst, mulShort, mulLong;
	uopPkg::armInstr blFirst, blSecond;
	uopPkg::armInstr ldmLoad, ldmCancel;

	// Holds while the pipeline stalls
	always_ff @(posedge clk) begin
		if (reset)
			state <= uopPkg::seqReady;
		else if (!stall)
			state <= nextState;
	end

	// Instruction classes, decoded through the data processing view
	always_comb begin
		isBx = (instr.dp.opcode == uopPkg::opTeq) && !instr.dp.setFlags
			&& (instr.dp.rn == uopPkg::pcReg) && (instr.dp.rd == uopPkg::pcReg)
			&& (instr.dp.operand2[11:4] == uopPkg::bxOp2High);
		isRsr = (instr.dp.kind == uopPkg::kindDataProc) && !instr.dp.immFlag
			&& !instr.dp.operand2[7] && instr.dp.operand2[4] && !isBx; // Shift by Rs
		isMulAcc = (instr.dp.kind == uopPkg::kindDataProc) && !instr.dp.immFlag
			&& instr.dp.opcode[0] && (instr.dp.operand2[7:4] == uopPkg::mulSignature); // A bit
		isBl = (instr.dp.kind == uopPkg::kindBranch) && instr.dp.immFlag
			&& instr.dp.opcode[3];                   // L bit
		isLdm = (instr.ls.kind == uopPkg::kindBlock) && instr.ls.load;
	end

	// Micro-op words
	always_comb begin
		rsrFirst = instr;
		rsrFirst.dp.opcode = uopPkg::opMov;          // MOV Rz, Rm shift Rs
		rsrFirst.dp.setFlags = 1'b0;
		rsrFirst.dp.rn = '0;
		rsrFirst.dp.rd = uopPkg::rzReg;
		rsrSecond = instr;
		rsrSecond.dp.operand2 = {8'b0, uopPkg::rzReg}; // Unshifted Rz

		mulFirst = instr;                            // MUL Rz, keep U for long forms
		mulFirst.dp.opcode = {instr.dp.opcode[3], 1'b0, instr.dp.opcode[1], 1'b0};
		mulFirst.dp.setFlags = 1'b0;
		mulFirst.dp.rn = uopPkg::rzReg;              // Multiply Rd sits at 19:16
		mulFirst.dp.rd = '0;
		mulShort.dp = '{cond: instr.dp.cond, kind: uopPkg::kindDataProc, immFlag: 1'b0,
			opcode: uopPkg::opAdd, setFlags: instr.dp.setFlags, rn: uopPkg::rzReg,
			rd: instr.dp.rn, operand2: {8'b0, instr.dp.rd}}; // Rd = Rz + Ra
		mulLong = instr;
		mulLong.dp.opcode = {instr.dp.opcode[3], 3'b101}; // Long accumulate
		mulLong.dp.operand2 = {instr.dp.rd, uopPkg::mulSignature, instr.dp.rn}; // RdLo, RdHi

		blFirst.dp = '{cond: instr.dp.cond, kind: uopPkg::kindDataProc, immFlag: 1'b0,
			opcode: uopPkg::opMov, setFlags: 1'b0, rn: '0, rd: uopPkg::lrReg,
			operand2: {8'b0, uopPkg::pcReg}};        // MOV LR, PC
		blSecond = instr;
		blSecond.dp.opcode[3] = 1'b0;                // Drop link bit

		ldmLoad.ls = '{cond: instr.ls.cond, kind: uopPkg::kindSingle, preIndex: 1'b1,
			up: walk.addUp, byteMode: 1'b0, writeBack: 1'b0, load: 1'b1,
			rn: instr.ls.rn, rd: walk.regNum, offset: walk.offset}; // LDR Rd, [Rn, #off]
		ldmCancel.dp = '{cond: uopPkg::opNeverCond, kind: uopPkg::kindDataProc, immFlag: 1'b1,
			opcode: uopPkg::opAdd, setFlags: 1'b0, rn: '0, rd: '0, operand2: '0};
	end

	// Mealy output and next state
	always_comb begin
		nextState = state;
		instrMux = 1'b0;
		noFlagUpdate = 1'b0;
		uopStall = 1'b0;
		keepV = 1'b0;
		prevRsr = 1'b0;
		ldmForward = 1'b0;
		regFileRz = 4'b0000;
		uopInstr = instr;                            // Pass through
		walk.ldmStart = 1'b0;
		walk.advance = 1'b0;
		case (state)
			uopPkg::seqReady: begin
				if (isRsr) begin
					instrMux = 1'b1;
					noFlagUpdate = 1'b1;
					uopStall = 1'b1;
					regFileRz = 4'b1100;             // Rz as destination
					uopInstr = rsrFirst;
					nextState = uopPkg::seqRsr;
				end else if (isMulAcc) begin
					instrMux = 1'b1;
					uopStall = 1'b1;
					keepV = 1'b1;                    // MUL leaves V alone
					regFileRz = 4'b1100;
					uopInstr = mulFirst;
					nextState = uopPkg::seqMultiply;
				end else if (isBl) begin
					instrMux = 1'b1;
					uopStall = 1'b1;
					uopInstr = blFirst;
					nextState = uopPkg::seqBl;
				end else if (isLdm) begin
					instrMux = 1'b1;
					noFlagUpdate = 1'b1;
					uopStall = !walk.lastReg;        // Single register needs one pass
					walk.ldmStart = 1'b1;
					uopInstr = ldmLoad;
					nextState = walk.lastReg ? uopPkg::seqReady : uopPkg::seqLdm;
				end
			end
			uopPkg::seqRsr: begin
				instrMux = 1'b1;
				prevRsr = 1'b1;
				regFileRz = 4'b0010;                 // Rz as operand2
				uopInstr = rsrSecond;
				nextState = uopPkg::seqReady;
			end
			uopPkg::seqMultiply: begin
				instrMux = 1'b1;
				regFileRz = instr.dp.opcode[2] ? 4'b0000 : 4'b0001; // Rz as Rn when short
				uopInstr = instr.dp.opcode[2] ? mulLong : mulShort;
				nextState = uopPkg::seqReady;
			end
			uopPkg::seqBl: begin
				instrMux = 1'b1;
				uopInstr = blSecond;
				nextState = uopPkg::seqReady;
			end
			uopPkg::seqLdm: begin
				instrMux = 1'b1;
				noFlagUpdate = 1'b1;
				if (!condPass) begin
					uopInstr = ldmCancel;            // Flags turned, abandon the rest
					nextState = uopPkg::seqReady;
				end else begin
					uopStall = !walk.lastReg;
					ldmForward = 1'b1;
					walk.advance = !stall;
					uopInstr = ldmLoad;
					nextState = walk.lastReg ? uopPkg::seqReady : uopPkg::seqLdm;
				end
			end
			default: nextState = uopPkg::seqReady;
		endcase
	end

	// Fetch must be held before any expansion begins
	assert property (@(posedge clk) disable iff (reset)
		(state == uopPkg::seqReady && !stall && !uopStall) |=> (state == uopPkg::seqReady))
		else $error("Sequencer left seqReady without stalling fetch");

endmodule

/* hw/uopSequencer.sv */
// Decode-stage micro-op sequencer where LDM base writeback is ignored and stores pass through unexpanded
module uopSequencer (
	input logic clk,
	input logic reset,
	input logic [uopPkg::instrWidth-1:0] instr,     // Decoded instruction word
	input logic stall,                              // Pipeline stall
	input logic [3:0] flags,                        // NZCV
	output logic instrMux,                          // Select uopInstr
	output logic noFlagUpdate,
	output logic uopStall,                          // Hold fetch
	output logic keepV,
	output logic prevRsr,
	output logic ldmForward,
	output logic [3:0] regFileRz,                   // Rz mux controls
	output logic [uopPkg::instrWidth-1:0] uopInstr
);

	logic condPass;

	ldmWalkIf walkBus ();

	condCheck condCheck_i (
		.cond(instr[31:28]),                        // Condition field
		.flags(flags),
		.condPass(condPass)
	);

	regListWalker walker_i (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.walk(walkBus.walker)
	);

	uopExpander expander_i (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.instr(instr),
		.condPass(condPass),
		.walk(walkBus.expander),
		.instrMux(instrMux),
		.noFlagUpdate(noFlagUpdate),
		.uopStall(uopStall),
		.keepV(keepV),
		.prevRsr(prevRsr),
		.ldmForward(ldmForward),
		.regFileRz(regFileRz),
		.uopInstr(uopInstr)
	);

endmodule

/* bench/clockGen.sv */
// Free-running clock from time zero; reset drops on the falling edge after five rising edges
module clockGen (
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int halfPeriod = 50;        // 100 ns period
	localparam int resetCycles = 5;

	initial clk = 1'b0;

	always #halfPeriod clk = ~clk;

	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);                    // Release away from the sampling edge
		reset = 1'b0;
	end

endmodule

/* bench/uopSequencerTb.sv */
// Needs bench/uopPatterns.txt reachable from the run directory; the DUT must sit in seqReady after reset
module uopSequencerTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int clkPeriod = 100;
	localparam int sampleDelay = 40;             // Before the next rising edge
	localparam int colCount = 12;                // Words per pattern line
	localparam int maxPatterns = 64;
	localparam int edgeLimit = 3 * clkPeriod;    // In 1 ns polls
	localparam int resetLimit = 20 * clkPeriod;
	localparam int randomCount = 20;
	localparam int randomTest = 8;

	logic clk;
	logic reset;
	logic [31:0] instr;
	logic stall;
	logic [3:0] flags;
	logic instrMux, noFlagUpdate, uopStall, keepV, prevRsr, ldmForward;
	logic [3:0] regFileRz;
	logic [31:0] uopInstr;

	logic [31:0] patMem [0:colCount*maxPatterns]; // Count word, then the lines
	int patCount = 0;
	int fallCount = 0;
	int checks = 0;
	int errors = 0;
	int testChecks = 0;
	int testErrors = 0;
	int curTest = 0;
	int seed = 73162;
	bit aborted = 1'b0;

	clockGen clockGen_i (
		.clk(clk),
		.reset(reset)
	);

	uopSequencer dut_i (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.stall(stall),
		.flags(flags),
		.instrMux(instrMux),
		.noFlagUpdate(noFlagUpdate),
		.uopStall(uopStall),
		.keepV(keepV),
		.prevRsr(prevRsr),
		.ldmForward(ldmForward),
		.regFileRz(regFileRz),
		.uopInstr(uopInstr)
	);

	always @(negedge clk) fallCount++;       // Edge counter for the polling waits

	function automatic string testName(input int id);
		case (id)
			1: return "pass-through";
			2: return "RSR expansion";
			3: return "multiply-accumulate";
			4: return "branch with link";
			5: return "LDM addressing modes";
			6: return "LDM condition cancel";
			7: return "stall hold";
			default: return "random pass-through";
		endcase
	endfunction

	task automatic reportTest();
		$display("Test %0d %s: %s, %0d checks, %0d errors", curTest, testName(curTest),
			(testErrors == 0) ? "passed" : "failed", testChecks, testErrors);
	endtask

	task automatic startTest(input int id);
		if (curTest != 0)
			reportTest();                        // Close the previous test
		curTest = id;
		testChecks = 0;
		testErrors = 0;
	endtask

	// Polls at half-ns offsets so it never lands on a clock edge
	task automatic waitForFall();
		int start;
		int waited;
		start = fallCount;
		waited = 0;
		while (fallCount == start && waited < edgeLimit) begin
			#1;
			waited++;
		end
		if (fallCount == start) begin
			$display("Timeout: no falling clock edge within %0d ns", edgeLimit);
			aborted = 1'b1;
		end
	endtask

	task automatic waitForResetRelease();
		int waited;
		waited = 0;
		while (reset !== 1'b0 && waited < resetLimit) begin
			#1;
			waited++;
		end
		if (reset !== 1'b0) begin
			$display("Timeout: reset still asserted after %0d ns", resetLimit);
			aborted = 1'b1;
		end
	endtask

	task automatic compareValue(input string name, input int line, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		testChecks++;
		if (got !== want) begin
			errors++;
			testErrors++;
			$display("ERROR at %0t: %s is %h, expected %h (test %0d, line %0d)", $time, name,
				got, want, curTest, line);
		end
	endtask

	initial begin
		int base;
		logic [31:0] word;
		instr = '0;
		stall = 1'b0;
		flags = '0;
		$readmemh("bench/uopPatterns.txt", patMem);
		if (patMem[0] > 0 && patMem[0] <= maxPatterns) begin
			patCount = patMem[0];
		end else begin
			$display("Pattern file bench/uopPatterns.txt is missing or has a bad line count");
			aborted = 1'b1;
		end
		#0.5;                                    // Off the clock edge grid
		if (!aborted)
			waitForResetRelease();
		for (int p = 0; p < patCount && !aborted; p++) begin
			base = 1 + p * colCount;
			if (patMem[base] != curTest)
				startTest(patMem[base]);
			waitForFall();
			if (!aborted) begin
				instr = patMem[base + 1];
				flags = patMem[base + 2][3:0];
				stall = patMem[base + 3][0];
				#sampleDelay;                    // Mealy outputs settled
				compareValue("instrMux", p, {31'b0, instrMux}, patMem[base + 4]);
				compareValue("noFlagUpdate", p, {31'b0, noFlagUpdate}, patMem[base + 5]);
				compareValue("uopStall", p, {31'b0, uopStall}, patMem[base + 6]);
				compareValue("keepV", p, {31'b0, keepV}, patMem[base + 7]);
				compareValue("prevRsr", p, {31'b0, prevRsr}, patMem[base + 8]);
				compareValue("ldmForward", p, {31'b0, ldmForward}, patMem[base + 9]);
				compareValue("regFileRz", p, {28'b0, regFileRz}, patMem[base + 10]);
				compareValue("uopInstr", p, uopInstr, patMem[base + 11]);
			end
		end
		if (!aborted)
			startTest(randomTest);
		for (int r = 0; r < randomCount && !aborted; r++) begin
			waitForFall();
			if (!aborted) begin
				word = $random(seed);
				word[27:25] = 3'b001;            // Data processing immediate, never expanded
				instr = word;
				flags = 4'($random(seed));
				stall = 1'b0;
				#sampleDelay;
				compareValue("instrMux", r, {31'b0, instrMux}, 32'd0);
				compareValue("uopStall", r, {31'b0, uopStall}, 32'd0);
				compareValue("uopInstr", r, uopInstr, word);
			end
		end
		if (curTest != 0)
			reportTest();
		$display("Totals: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && !aborted)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* bench/uopPatterns.txt */
// First word is the number of pattern lines, then one cycle per line, all values hex
// test instr flags stall | instrMux noFlagUpdate uopStall keepV prevRsr ldmForward regFileRz uopInstr
22
1 E2821005 0 0 0 0 0 0 0 0 0 E2821005
1 E0821103 0 0 0 0 0 0 0 0 0 E0821103
2 E0921413 0 0 1 1 1 0 0 0 C E1A0F413
2 E0921413 0 0 1 0 0 0 1 0 2 E092100F
3 E0253291 0 0 1 0 1 1 0 0 C E00F0291
3 E0253291 0 0 1 0 0 0 0 0 1 E08F5003
3 E0A54291 0 0 1 0 1 1 0 0 C E00F0291
3 E0A54291 0 0 1 0 0 0 0 0 0 E0A54495
4 EB000010 0 0 1 0 1 0 0 0 0 E1A0E00F
4 EB000010 0 0 1 0 0 0 0 0 0 EA000010
5 E8900052 0 0 1 1 1 0 0 0 0 E5901000
5 E8900052 0 0 1 1 1 0 0 1 0 E5904004
5 E8900052 0 0 1 1 0 0 0 1 0 E5906008
5 E9900052 0 0 1 1 1 0 0 0 0 E5901004
5 E9900052 0 0 1 1 1 0 0 1 0 E5904008
5 E9900052 0 0 1 1 0 0 0 1 0 E590600C
5 E8100052 0 0 1 1 1 0 0 0 0 E5101008
5 E8100052 0 0 1 1 1 0 0 1 0 E5104004
5 E8100052 0 0 1 1 0 0 0 1 0 E5906000
5 E9100052 0 0 1 1 1 0 0 0 0 E510100C
5 E9100052 0 0 1 1 1 0 0 1 0 E5104008
5 E9100052 0 0 1 1 0 0 0 1 0 E5106004
6 08900052 4 0 1 1 1 0 0 0 0 05901000
6 08900052 0 0 1 1 0 0 0 0 0 F2800000
6 E2821005 0 0 0 0 0 0 0 0 0 E2821005
7 E0921413 0 1 1 1 1 0 0 0 C E1A0F413
7 E0921413 0 1 1 1 1 0 0 0 C E1A0F413
7 E0921413 0 0 1 1 1 0 0 0 C E1A0F413
7 E0921413 0 0 1 0 0 0 1 0 2 E092100F
7 E8900052 0 0 1 1 1 0 0 0 0 E5901000
7 E8900052 0 1 1 1 1 0 0 1 0 E5904004
7 E8900052 0 1 1 1 1 0 0 1 0 E5904004
7 E8900052 0 0 1 1 1 0 0 1 0 E5904004
7 E8900052 0 0 1 1 0 0 0 1 0 E5906008

/* verilog.f */
hw/uopPkg.sv
hw/ldmWalkIf.sv
hw/condCheck.sv
hw/regListWalker.sv
hw/uopExpander.sv
hw/uopSequencer.sv
bench/clockGen.sv
bench/uopSequencerTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	-f verilog.f --top-module uopSequencerTb -o uopSim &&
./obj_dir/uopSim | tee /dev/stderr | grep -qx "Finished with no errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
